// File: hdl/muldiv_cfg.svh
// --------------------
// sizing macros for the multiply and divide unit
// register count, queue depths, writeback credits
// and the divider iteration count
// --------------------

`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// number of general purpose registers
`define MULDIV_NUM_GPR 32

// depth of the instruction queue and the credits the host holds after reset
`define MULDIV_INST_DEPTH 4

// writeback credits held by the unit after reset
// this must match the buffer space on the consumer side
`define MULDIV_WB_CREDITS 2

// iterations of the shift-subtract divider
`define MULDIV_DIV_STEPS 32

`endif

// File: hdl/muldiv_pkg.sv
// --------------------
// shared types of the multiply and divide unit
// opcodes, instruction layout, issue command,
// execution feedback, register write and writeback record
// --------------------

`default_nettype none

package muldiv_pkg;

	// primary opcodes handled here
	typedef enum logic [5:0] {
		Op_mulli  = 6'd7,
		Op_alu_xo = 6'd31
	} opcd_e;

	// extended opcodes of the XO form
	typedef enum logic [8:0] {
		Xop_mulhwu = 9'd11,
		Xop_mulhw  = 9'd75,
		Xop_mullw  = 9'd235,
		Xop_divwu  = 9'd459,
		Xop_divw   = 9'd491
	} xop_e;

	// XO-form instruction word from the msb down
	// for mulli the low 16 bits hold the signed immediate instead
	typedef struct packed {
		opcd_e      opcd;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic       oe;
		xop_e       xo;
		logic       rc;
	} inst_xo_t;

	// which functional unit an issue goes to
	typedef enum logic [1:0] {
		Fu_none = 2'd0,
		Fu_mul  = 2'd1,
		Fu_div  = 2'd2
	} fu_sel_e;

	// command from the decoder to the execution block
	typedef struct packed {
		fu_sel_e     fxdp_sel;
		logic        mul_high;
		logic        mul_unsigned;
		logic        div_unsigned;
		logic        check_ov;
		logic [31:0] a;
		logic [31:0] b;
	} control_word_t;

	// completion feedback where one complete bit pulses per operation
	typedef struct packed {
		logic        mul_complete;
		logic        div_complete;
		logic [31:0] result;
		logic        ov;
	} fxdp_fb_t;

	// a single register write
	typedef struct packed {
		logic        en;
		logic [4:0]  idx;
		logic [31:0] data;
	} gpr_wr_t;

	// record sent out for every retired instruction
	// cr holds lt, gt, eq, so from msb to lsb
	typedef struct packed {
		logic        illegal;
		logic [4:0]  rt;
		logic [31:0] value;
		logic [3:0]  cr;
		logic        cr_valid;
		logic        ov;
		logic        ov_valid;
	} wb_rec_t;

endpackage

`default_nettype wire

// File: hdl/credit_fifo.sv
// --------------------
// receiver-side queue for a credit-based stream
// circular buffer of any payload type, one credit
// returned for every pop
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module credit_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = `MULDIV_INST_DEPTH
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty,
	output logic     credit
);

	localparam int AW = $clog2(DEPTH);

	// storage for the queued words
	payload_t mem [DEPTH];

	// pointers carry one extra wrap bit to tell full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;

	assign empty    = (wr_ptr == rd_ptr);
	assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign pop_data = mem[rd_ptr[AW-1:0]];

	// --------------------
	// pointer and credit control

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			credit <= 1'b0;
		end else begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
			// the sender gets its slot back in the cycle after the pop
			credit <= pop && !empty;
		end
	end

	// --------------------
	// storage write

	always_ff @(posedge clk) begin
		if (push && !full)
			mem[wr_ptr[AW-1:0]] <= push_data;
	end

endmodule

`default_nettype wire

// File: hdl/gpr_file.sv
// --------------------
// general purpose register file
// host preload port, writeback port and
// two combinational read ports
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module gpr_file (
	input  logic                clk,
	input  logic                reset,
	input  muldiv_pkg::gpr_wr_t host_wr,
	input  muldiv_pkg::gpr_wr_t wb_wr,
	input  logic [4:0]          rd_a_idx,
	input  logic [4:0]          rd_b_idx,
	output logic [31:0]         rd_a,
	output logic [31:0]         rd_b
);

	logic [31:0] regs [`MULDIV_NUM_GPR];

	// reads see the array directly
	assign rd_a = regs[rd_a_idx];
	assign rd_b = regs[rd_b_idx];

	// the host loads registers while the unit is idle
	// writeback wins if both ever land in the same cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `MULDIV_NUM_GPR; i++)
				regs[i] <= '0;
		end else begin
			if (wb_wr.en)
				regs[wb_wr.idx] <= wb_wr.data;
			else if (host_wr.en)
				regs[host_wr.idx] <= host_wr.data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fixedpoint_exec.sv
// --------------------
// execution block with a two-stage multiplier and
// an iterative restoring divider
// reports each completion with a one-cycle pulse
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module fixedpoint_exec (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      issue,
	input  muldiv_pkg::control_word_t cw,
	output muldiv_pkg::fxdp_fb_t      fb
);
	import muldiv_pkg::*;

	localparam int CNT_W = $clog2(`MULDIV_DIV_STEPS + 1);

	logic signed [32:0] mul_a_ext;
	logic signed [32:0] mul_b_ext;
	logic signed [65:0] mul_full;
	logic               mul_s1_valid;
	logic [63:0]        mul_s1_prod;
	logic               mul_s1_high;
	logic               mul_s1_chk;
	logic               mul_done;
	logic [31:0]        mul_result;
	logic               mul_ov;

	logic               div_busy;
	logic [CNT_W-1:0]   div_cnt;
	logic [31:0]        div_rem;
	logic [31:0]        div_quo;
	logic [31:0]        div_dvs;
	logic               div_neg;
	logic               div_bad;
	logic               div_chk;
	logic               div_done;
	logic [31:0]        div_result;
	logic               div_ov;
	logic [31:0]        dvd_mag;
	logic [31:0]        dvs_mag;
	logic [32:0]        step_shift;
	logic [33:0]        step_diff;
	logic [31:0]        step_quo;
	logic [31:0]        quo_fixed;

	// --------------------
	// multiplier

	// one extra bit gives a single signed multiply for both signednesses
	assign mul_a_ext = {!cw.mul_unsigned && cw.a[31], cw.a};
	assign mul_b_ext = {!cw.mul_unsigned && cw.b[31], cw.b};
	assign mul_full  = mul_a_ext * mul_b_ext;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mul_s1_valid <= 1'b0;
			mul_done     <= 1'b0;
		end else begin
			mul_s1_valid <= issue && (cw.fxdp_sel == Fu_mul);
			mul_done     <= mul_s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			mul_s1_prod <= mul_full[63:0];
			mul_s1_high <= cw.mul_high;
			mul_s1_chk  <= cw.check_ov;
		end
		// second stage picks the word and checks the signed 32-bit range
		if (mul_s1_valid) begin
			mul_result <= mul_s1_high ? mul_s1_prod[63:32] : mul_s1_prod[31:0];
			mul_ov     <= mul_s1_chk && (mul_s1_prod[63:32] != {32{mul_s1_prod[31]}});
		end
	end

	// --------------------
	// divider

	// the divider works on magnitudes and fixes the sign at the end
	assign dvd_mag = (!cw.div_unsigned && cw.a[31]) ? -cw.a : cw.a;
	assign dvs_mag = (!cw.div_unsigned && cw.b[31]) ? -cw.b : cw.b;

	// one restoring step shifts the next dividend bit into the remainder
	// the remainder stays below the divisor and so fits in 32 bits
	assign step_shift = {div_rem, div_quo[31]};
	assign step_diff  = {1'b0, step_shift} - {2'b00, div_dvs};
	assign step_quo   = {div_quo[30:0], !step_diff[33]};
	assign quo_fixed  = div_neg ? -step_quo : step_quo;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			div_busy <= 1'b0;
			div_cnt  <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= div_busy && (div_cnt == CNT_W'(1));
			if (issue && (cw.fxdp_sel == Fu_div)) begin
				div_busy <= 1'b1;
				div_cnt  <= CNT_W'(`MULDIV_DIV_STEPS);
			end else if (div_busy) begin
				div_cnt <= div_cnt - 1'b1;
				if (div_cnt == CNT_W'(1))
					div_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			div_rem <= '0;
			div_quo <= dvd_mag;
			div_dvs <= dvs_mag;
			div_neg <= !cw.div_unsigned && (cw.a[31] ^ cw.b[31]);
			div_chk <= cw.check_ov;
			// zero divisor and the one signed case whose quotient does not fit
			div_bad <= (cw.b == '0) ||
				(!cw.div_unsigned && (cw.a == 32'h8000_0000) && (cw.b == 32'hffff_ffff));
		end else if (div_busy) begin
			div_rem <= step_diff[33] ? step_shift[31:0] : step_diff[31:0];
			div_quo <= step_quo;
			if (div_cnt == CNT_W'(1)) begin
				div_result <= div_bad ? '0 : quo_fixed;
				div_ov     <= div_chk && div_bad;
			end
		end
	end

	// --------------------
	// feedback to the decoder

	always_comb begin
		fb.mul_complete = mul_done;
		fb.div_complete = div_done;
		fb.result       = mul_done ? mul_result : div_result;
		fb.ov           = mul_done ? mul_ov : div_ov;
	end

endmodule

`default_nettype wire

// File: hdl/mul_div_decode.sv
// --------------------
// decoder and issue control for mulli, mulhw, mulhwu,
// mullw, divw and divwu
// holds until the execution block completes, then writes
// the register and emits the writeback record
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module mul_div_decode (
	input  logic                      clk,
	input  logic                      reset,
	input  muldiv_pkg::inst_xo_t      inst,
	input  logic                      empty,
	output logic                      pop,
	output logic [4:0]                rd_a_idx,
	output logic [4:0]                rd_b_idx,
	input  logic [31:0]               rd_a,
	input  logic [31:0]               rd_b,
	output logic                      issue,
	output muldiv_pkg::control_word_t cw,
	input  muldiv_pkg::fxdp_fb_t      fb,
	output muldiv_pkg::gpr_wr_t       wb_wr,
	output logic                      wb_valid,
	output muldiv_pkg::wb_rec_t       wb,
	input  logic                      wb_credit
);
	import muldiv_pkg::*;

	localparam int CRW = $clog2(`MULDIV_WB_CREDITS + 1);

	// idle waits for work, issue reads operands, wait holds until completion
	typedef enum logic [1:0] {
		St_idle,
		St_issue,
		St_wait
	} state_e;

	state_e          state;
	inst_xo_t        inst_q;
	logic [31:0]     inst_bits;
	logic [CRW-1:0]  wb_cnt;
	logic            legal;
	logic            is_mulli;
	logic            is_div;
	logic            mul_high;
	logic            mul_uns;
	logic            div_uns;
	logic            chk_ov;
	logic            done;
	logic            illegal_out;
	logic            res_ov;

	assign inst_bits = inst_q;

	// --------------------
	// decode of the held instruction

	always_comb begin
		legal    = 1'b0;
		is_mulli = 1'b0;
		is_div   = 1'b0;
		mul_high = 1'b0;
		mul_uns  = 1'b0;
		div_uns  = 1'b0;
		chk_ov   = 1'b0;
		case (inst_q.opcd)
			Op_mulli: begin
				legal    = 1'b1;
				is_mulli = 1'b1;
			end
			Op_alu_xo: begin
				case (inst_q.xo)
					Xop_mulhw: begin
						legal    = 1'b1;
						mul_high = 1'b1;
					end
					Xop_mulhwu: begin
						legal    = 1'b1;
						mul_high = 1'b1;
						mul_uns  = 1'b1;
					end
					Xop_mullw: begin
						legal  = 1'b1;
						chk_ov = 1'b1;
					end
					Xop_divw: begin
						legal  = 1'b1;
						is_div = 1'b1;
						chk_ov = 1'b1;
					end
					Xop_divwu: begin
						legal   = 1'b1;
						is_div  = 1'b1;
						div_uns = 1'b1;
						chk_ov  = 1'b1;
					end
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	// --------------------
	// handshakes and the issue command

	// only one instruction is in flight, so a free credit now covers its record
	assign pop         = (state == St_idle) && !empty && (wb_cnt != '0);
	assign issue       = (state == St_issue) && legal;
	assign illegal_out = (state == St_issue) && !legal;
	assign done        = (state == St_wait) && (fb.mul_complete || fb.div_complete);
	assign wb_valid    = done || illegal_out;

	assign rd_a_idx = inst_q.ra;
	assign rd_b_idx = inst_q.rb;

	always_comb begin
		cw.fxdp_sel     = !legal ? Fu_none : (is_div ? Fu_div : Fu_mul);
		cw.mul_high     = mul_high;
		cw.mul_unsigned = mul_uns;
		cw.div_unsigned = div_uns;
		// mulhw and mulhwu never report overflow
		cw.check_ov     = chk_ov;
		cw.a            = rd_a;
		// mulli takes its sign-extended immediate in place of rb
		cw.b            = is_mulli ? {{16{inst_bits[15]}}, inst_bits[15:0]} : rd_b;
	end

	// --------------------
	// register write and writeback record

	assign wb_wr.en   = done;
	assign wb_wr.idx  = inst_q.rt;
	assign wb_wr.data = fb.result;

	// overflow is reported only when oe is set on mullw, divw or divwu
	assign res_ov = inst_q.oe && chk_ov && fb.ov;

	always_comb begin
		wb          = '0;
		wb.rt       = inst_q.rt;
		wb.illegal  = illegal_out;
		if (done) begin
			wb.value    = fb.result;
			wb.ov       = res_ov;
			wb.ov_valid = inst_q.oe && chk_ov;
			// CR0 is never touched by mulli
			if (inst_q.rc && !is_mulli) begin
				wb.cr_valid = 1'b1;
				wb.cr       = {fb.result[31], !fb.result[31] && (fb.result != '0),
					(fb.result == '0), res_ov};
			end
		end
	end

	// --------------------
	// state, instruction register and credit counter

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state  <= St_idle;
			wb_cnt <= CRW'(`MULDIV_WB_CREDITS);
		end else begin
			case (state)
				St_idle:  if (pop) state <= St_issue;
				St_issue: state <= legal ? St_wait : St_idle;
				St_wait:  if (done) state <= St_idle;
				default:  state <= St_idle;
			endcase
			case ({wb_valid, wb_credit})
				2'b10:   wb_cnt <= wb_cnt - 1'b1;
				2'b01:   wb_cnt <= wb_cnt + 1'b1;
				default: wb_cnt <= wb_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			inst_q <= inst;
	end

endmodule

`default_nettype wire

// File: hdl/muldiv_unit.sv
// --------------------
// top level of the multiply and divide unit
// instruction queue, decoder, execution block
// and register file
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module muldiv_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 inst_valid,
	input  muldiv_pkg::inst_xo_t inst,
	output logic                 inst_credit,
	input  muldiv_pkg::gpr_wr_t  host_wr,
	output logic                 wb_valid,
	output muldiv_pkg::wb_rec_t  wb,
	input  logic                 wb_credit
);
	import muldiv_pkg::*;

	inst_xo_t      q_inst;
	logic          q_empty;
	logic          q_pop;
	logic [4:0]    rd_a_idx;
	logic [4:0]    rd_b_idx;
	logic [31:0]   rd_a;
	logic [31:0]   rd_b;
	logic          issue;
	control_word_t cw;
	fxdp_fb_t      fb;
	gpr_wr_t       wb_wr;

	// --------------------
	// the instruction queue hands its credits straight back to the host
	credit_fifo #(
		.payload_t (inst_xo_t),
		.DEPTH     (`MULDIV_INST_DEPTH)
	) inst_queue (
		.clk       (clk),
		.reset     (reset),
		.push      (inst_valid),
		.push_data (inst),
		.pop       (q_pop),
		.pop_data  (q_inst),
		.empty     (q_empty),
		.credit    (inst_credit)
	);

	mul_div_decode decoder (
		.clk       (clk),
		.reset     (reset),
		.inst      (q_inst),
		.empty     (q_empty),
		.pop       (q_pop),
		.rd_a_idx  (rd_a_idx),
		.rd_b_idx  (rd_b_idx),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.issue     (issue),
		.cw        (cw),
		.fb        (fb),
		.wb_wr     (wb_wr),
		.wb_valid  (wb_valid),
		.wb        (wb),
		.wb_credit (wb_credit)
	);

	fixedpoint_exec exec_unit (
		.clk   (clk),
		.reset (reset),
		.issue (issue),
		.cw    (cw),
		.fb    (fb)
	);

	gpr_file regs (
		.clk      (clk),
		.reset    (reset),
		.host_wr  (host_wr),
		.wb_wr    (wb_wr),
		.rd_a_idx (rd_a_idx),
		.rd_b_idx (rd_b_idx),
		.rd_a     (rd_a),
		.rd_b     (rd_b)
	);

endmodule

`default_nettype wire

// File: tb/muldiv_unit_chk.sv
// --------------------
// concurrent assertions for the multiply and divide unit
// bound into the instruction queue and into the decoder
// covers queue overflow, issue hold, completion and reset state
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module muldiv_unit_chk (
	input logic       clk,
	input logic       reset,
	input logic       push,
	input logic       full,
	input logic       issue,
	input logic       complete,
	input logic [4:0] ctrl
);

	// an operation is outstanding from issue until its completion pulse
	logic       pending;
	logic [7:0] wait_cnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending  <= 1'b0;
			wait_cnt <= 8'd0;
		end else if (issue) begin
			pending  <= 1'b1;
			wait_cnt <= 8'd0;
		end else if (complete) begin
			pending <= 1'b0;
		end else if (pending) begin
			wait_cnt <= wait_cnt + 8'd1;
		end
	end

	// the host only pushes while it holds a credit, so the queue never overflows
	a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("push into a full instruction queue");

	// one operation at a time
	a_issue_idle: assert property (@(posedge clk) disable iff (reset) issue |-> !pending)
		else $error("issue while an operation is still outstanding");

	a_complete_after_issue: assert property (
		@(posedge clk) disable iff (reset) complete |-> pending)
		else $error("completion without an outstanding issue");

	// the divider is the slowest case at MULDIV_DIV_STEPS+1 cycles
	a_complete_in_time: assert property (
		@(posedge clk) disable iff (reset) pending |-> (wait_cnt <= `MULDIV_DIV_STEPS + 1))
		else $error("no completion after issue");

	a_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> (ctrl == 5'd0))
		else $error("control outputs not low out of reset");

endmodule

bind credit_fifo muldiv_unit_chk fifo_chk (
	.clk      (clk),
	.reset    (reset),
	.push     (push),
	.full     (full),
	.issue    (1'b0),
	.complete (1'b0),
	.ctrl     ({4'b0000, credit})
);

bind mul_div_decode muldiv_unit_chk decode_chk (
	.clk      (clk),
	.reset    (reset),
	.push     (1'b0),
	.full     (1'b0),
	.issue    (issue),
	.complete (fb.mul_complete || fb.div_complete),
	.ctrl     ({issue, wb_valid, pop, fb.mul_complete, fb.div_complete})
);

`default_nettype wire

// File: tb/muldiv_unit_tb.sv
// --------------------
// testbench for the multiply and divide unit
// clock and reset, a table of corner and LCG entries,
// a reference model for the records, host and consumer
// credit tracking and the compare tasks
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module muldiv_unit_tb;
	import muldiv_pkg::*;

	localparam int TIMEOUT = 400;
	localparam int DEPTH   = `MULDIV_INST_DEPTH;

	// one table row holds the ra and rb preload, the instruction word and its record
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] word;
		wb_rec_t     exp;
	} test_t;

	logic        clk;
	logic        reset;
	logic        inst_valid;
	inst_xo_t    inst;
	logic        inst_credit;
	gpr_wr_t     host_wr;
	logic        wb_valid;
	wb_rec_t     wb;
	logic        wb_credit;

	test_t       tests[$];
	wb_rec_t     got_q[$];
	int          host_credits;
	int          owed;
	logic        hold_credits;
	logic [31:0] rand_state;

	muldiv_unit muldiv_unit_inst (
		.clk         (clk),
		.reset       (reset),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.inst_credit (inst_credit),
		.host_wr     (host_wr),
		.wb_valid    (wb_valid),
		.wb          (wb),
		.wb_credit   (wb_credit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// --------------------
	// consumer and monitor

	// the consumer gives one writeback credit back per record unless held off
	always @(posedge clk) begin
		#2;
		if (owed > 0 && !hold_credits) begin
			wb_credit = 1'b1;
			owed--;
		end else begin
			wb_credit = 1'b0;
		end
	end

	// records and returned host credits are taken at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (wb_valid) begin
				got_q.push_back(wb);
				owed++;
			end
			if (inst_credit)
				host_credits++;
		end
	end

	// --------------------
	// failure reporting and compare tasks

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_wb(string name, wb_rec_t got, wb_rec_t exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			abort_run("writeback record mismatch");
		end
	endtask

	task automatic check_credit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			abort_run("credit signal mismatch");
		end
	endtask

	// --------------------
	// instruction and record builders

	// each queue slot owns its own ra, rb and rt so a batch has no hazards
	function automatic logic [4:0] ra_of(int slot);
		return 5'(1 + 3 * slot);
	endfunction

	function automatic logic [4:0] rb_of(int slot);
		return 5'(2 + 3 * slot);
	endfunction

	function automatic logic [4:0] rt_of(int slot);
		return 5'(3 + 3 * slot);
	endfunction

	function automatic logic [31:0] xo_word(logic [8:0] xo, logic oe, logic rc, int slot);
		return {6'd31, rt_of(slot), ra_of(slot), rb_of(slot), oe, xo, rc};
	endfunction

	function automatic logic [31:0] mulli_word(logic [15:0] imm, int slot);
		return {6'd7, rt_of(slot), ra_of(slot), imm};
	endfunction

	function automatic wb_rec_t rec(logic [4:0] rt, logic [31:0] value, logic [3:0] cr,
		logic cr_valid, logic ov, logic ov_valid);
		wb_rec_t r;
		r          = '0;
		r.rt       = rt;
		r.value    = value;
		r.cr       = cr;
		r.cr_valid = cr_valid;
		r.ov       = ov;
		r.ov_valid = ov_valid;
		return r;
	endfunction

	function automatic wb_rec_t illegal_rec(logic [4:0] rt);
		wb_rec_t r;
		r         = '0;
		r.rt      = rt;
		r.illegal = 1'b1;
		return r;
	endfunction

	// --------------------
	// reference model of one retired instruction

	function automatic wb_rec_t model_rec(logic [31:0] w, logic [31:0] a, logic [31:0] b);
		wb_rec_t     r;
		longint      ps;
		logic [63:0] pu;
		logic [8:0]  xo;
		logic        ovf;
		int          sa;
		int          sb;
		r       = '0;
		r.rt    = w[25:21];
		xo      = w[9:1];
		ovf     = 1'b0;
		sa      = a;
		sb      = b;
		ps      = longint'($signed(a)) * longint'($signed(b));
		pu      = {32'h0, a} * {32'h0, b};
		// mulli keeps only the low word and touches neither CR0 nor ov
		if (w[31:26] == 6'd7) begin
			ps      = longint'($signed(a)) * longint'($signed(w[15:0]));
			r.value = ps[31:0];
			return r;
		end
		if (w[31:26] != 6'd31)
			return illegal_rec(w[25:21]);
		case (xo)
			Xop_mullw: begin
				r.value = ps[31:0];
				ovf     = (ps > 64'sd2147483647) || (ps < -64'sd2147483648);
			end
			Xop_mulhw:  r.value = ps[63:32];
			Xop_mulhwu: r.value = pu[63:32];
			Xop_divw: begin
				if (b == 32'h0 || (a == 32'h8000_0000 && b == 32'hffff_ffff))
					ovf = 1'b1;
				else
					r.value = sa / sb;
			end
			Xop_divwu: begin
				if (b == 32'h0)
					ovf = 1'b1;
				else
					r.value = a / b;
			end
			default: return illegal_rec(w[25:21]);
		endcase
		if (xo == Xop_mullw || xo == Xop_divw || xo == Xop_divwu) begin
			r.ov_valid = w[10];
			r.ov       = w[10] && ovf;
		end
		if (w[0]) begin
			r.cr_valid = 1'b1;
			r.cr = {$signed(r.value) < 0, $signed(r.value) > 0, r.value == 32'h0, r.ov};
		end
		return r;
	endfunction

	// --------------------
	// stimulus table

	function logic [31:0] lcg_next();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic add_test(logic [31:0] a, logic [31:0] b, logic [31:0] w, wb_rec_t exp);
		test_t t;
		t.a    = a;
		t.b    = b;
		t.word = w;
		t.exp  = exp;
		tests.push_back(t);
	endtask

	// hand-computed corners in slot order with four per batch
	task automatic add_corners();
		add_test(32'd7, 32'd0, mulli_word(16'hfffd, 0), rec(3, 32'hffff_ffeb, 0, 0, 0, 0));
		add_test(32'h1_0000, 32'h1_0000, xo_word(Xop_mullw, 1, 1, 1),
			rec(6, 32'h0, 4'b0011, 1, 1, 1));
		add_test(32'hffff_fffe, 32'd3, xo_word(Xop_mulhw, 1, 1, 2),
			rec(9, 32'hffff_ffff, 4'b1000, 1, 0, 0));
		add_test(32'hffff_ffff, 32'hffff_ffff, xo_word(Xop_mulhwu, 0, 0, 3),
			rec(12, 32'hffff_fffe, 0, 0, 0, 0));
		// this batch of divide corners also runs with writeback credits held back
		add_test(32'd100, 32'd0, xo_word(Xop_divw, 1, 1, 0), rec(3, 32'h0, 4'b0011, 1, 1, 1));
		add_test(32'h8000_0000, 32'hffff_ffff, xo_word(Xop_divw, 1, 1, 1),
			rec(6, 32'h0, 4'b0011, 1, 1, 1));
		add_test(32'hffff_fff9, 32'd2, xo_word(Xop_divw, 0, 1, 2),
			rec(9, 32'hffff_fffd, 4'b1000, 1, 0, 0));
		add_test(32'hffff_ffff, 32'd2, xo_word(Xop_divwu, 1, 0, 3),
			rec(12, 32'h7fff_ffff, 0, 0, 0, 1));
		// the illegal word targets r4, which the next entry reads as ra
		add_test(32'd1, 32'd2, {6'd0, 5'd4, ra_of(0), rb_of(0), 11'd0}, illegal_rec(4));
		add_test(32'd5, 32'd6, xo_word(Xop_mullw, 1, 1, 1), rec(6, 32'h1e, 4'b0100, 1, 0, 1));
		add_test(32'd0, 32'd0, xo_word(Xop_divwu, 0, 1, 2), rec(9, 32'h0, 4'b0010, 1, 0, 0));
		add_test(32'd9, 32'd9, xo_word(9'd100, 0, 0, 3), illegal_rec(12));
	endtask

	task automatic add_random(int count);
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] w;
		int          slot;
		for (int i = 0; i < count; i++) begin
			r    = lcg_next();
			a    = lcg_next();
			b    = lcg_next();
			slot = tests.size() % DEPTH;
			// shorter divisors give quotients that are not mostly zero
			if (r[3])
				b = b >> r[8:4];
			case (r[2:0])
				3'd0:       w = mulli_word(r[31:16], slot);
				3'd1:       w = xo_word(Xop_mulhw, r[9], r[10], slot);
				3'd2:       w = xo_word(Xop_mulhwu, r[9], r[10], slot);
				3'd3, 3'd4: w = xo_word(Xop_divw, r[9], r[10], slot);
				3'd5:       w = xo_word(Xop_divwu, r[9], r[10], slot);
				default:    w = xo_word(Xop_mullw, r[9], r[10], slot);
			endcase
			add_test(a, b, w, model_rec(w, a, b));
		end
	endtask

	// --------------------
	// host side drivers and waits that are all entered 2 ns after a rising edge

	task automatic write_gpr(logic [4:0] idx, logic [31:0] data);
		host_wr.en   = 1'b1;
		host_wr.idx  = idx;
		host_wr.data = data;
		@(posedge clk);
		#2;
		host_wr.en = 1'b0;
	endtask

	task automatic push_word(logic [31:0] w);
		int t;
		t = 0;
		while (host_credits == 0) begin
			@(posedge clk);
			#2;
			t++;
			if (t > TIMEOUT)
				abort_run("timed out waiting for an instruction credit");
		end
		inst_valid = 1'b1;
		inst       = inst_xo_t'(w);
		host_credits--;
		@(posedge clk);
		#2;
		inst_valid = 1'b0;
	endtask

	task automatic wait_records(int n);
		int t;
		t = 0;
		while (got_q.size() < n) begin
			@(posedge clk);
			#2;
			t++;
			if (t > TIMEOUT)
				abort_run("timed out waiting for writeback records");
		end
	endtask

	// every record must have given back exactly one credit on each side
	task automatic wait_settled();
		int t;
		t = 0;
		while (owed != 0 || host_credits != DEPTH) begin
			@(posedge clk);
			#2;
			t++;
			if (t > TIMEOUT)
				abort_run("credits did not settle back to their reset values");
		end
	endtask

	task automatic run_batch(int first, logic hold);
		hold_credits = hold;
		for (int k = 0; k < DEPTH; k++) begin
			write_gpr(ra_of(k), tests[first + k].a);
			write_gpr(rb_of(k), tests[first + k].b);
		end
		got_q.delete();
		for (int k = 0; k < DEPTH; k++)
			push_word(tests[first + k].word);
		if (hold) begin
			wait_records(`MULDIV_WB_CREDITS);
			// long enough for every queued divide to finish had it been issued
			repeat (DEPTH * (`MULDIV_DIV_STEPS + 4)) @(posedge clk);
			#2;
			if (got_q.size() != `MULDIV_WB_CREDITS)
				abort_run("records arrived without a writeback credit");
			hold_credits = 1'b0;
		end
		wait_records(DEPTH);
		for (int k = 0; k < DEPTH; k++)
			check_wb($sformatf("wb record %0d", first + k), got_q[k], tests[first + k].exp);
		wait_settled();
		if (got_q.size() != DEPTH)
			abort_run("more writeback records than instructions in the batch");
	endtask

	// --------------------
	// main sequence

	initial begin
		reset        = 1'b1;
		inst_valid   = 1'b0;
		inst         = '0;
		host_wr      = '0;
		wb_credit    = 1'b0;
		hold_credits = 1'b0;
		host_credits = DEPTH;
		owed         = 0;
		rand_state   = 32'h84d4a96b;
		add_corners();
		add_random(24);
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		// nothing is queued yet, so both handshakes stay quiet
		repeat (3) begin
			@(negedge clk);
			check_credit("inst_credit", inst_credit, 1'b0);
			check_credit("wb_valid", wb_valid, 1'b0);
		end
		@(posedge clk);
		#2;
		for (int first = 0; first < tests.size(); first += DEPTH)
			run_batch(first, ((first / DEPTH) % 3) == 1);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/credit_fifo.sv
hdl/gpr_file.sv
hdl/fixedpoint_exec.sv
hdl/mul_div_decode.sv
hdl/muldiv_unit.sv
tb/muldiv_unit_chk.sv
tb/muldiv_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# the exit status of the simulation is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module muldiv_unit_tb -o muldiv_sim

./obj_dir/muldiv_sim
